//--- bench/recipEstimateMonitor.sv
// ==========================================================
// Reciprocal estimator monitor
// Queues expected results on enabled edges and compares
// result once each item has passed three enabled edges
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module recipEstimateMonitor (
	input logic clk,
	input logic reset,
	input logic ce,
	input fpFormatPkg::float32T expected,
	input logic expValid,
	input fpFormatPkg::float32T result
);

	import fpFormatPkg::*;

	localparam int LATENCY = 3;

	typedef struct packed {
		logic valid;
		float32T value;
		logic [31:0] dueEdge;
	} itemT;

	itemT inFlight [$];
	int unsigned enabledEdges = 0;
	logic edgeWasEnabled = 1'b0;
	float32T lastResult = '0;
	int errorCount = 0;
	int checkCount = 0;
	int pending = 0;

	task automatic compareField(input string name, input logic [31:0] want,
			input logic [31:0] got);
		checkCount++;
		if (want !== got) begin
			errorCount++;
			$display("[ERROR] %s expected %h got %h at %0t", name, want, got, $time);
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			inFlight.delete();
			enabledEdges = 0;
			edgeWasEnabled = 1'b0;
			pending = 0;
		end else if (ce) begin
			enabledEdges++;
			inFlight.push_back('{valid: expValid, value: expected,
				dueEdge: enabledEdges + LATENCY - 1});
			edgeWasEnabled = 1'b1;
			if (expValid) begin
				pending++;
			end
		end else begin
			edgeWasEnabled = 1'b0;
		end
	end

	// Outputs are settled by the falling edge
	always @(negedge clk) begin
		itemT item;
		if (reset) begin
			compareField("result", '0, result);
		end else if (edgeWasEnabled && inFlight.size() > 0
				&& inFlight[0].dueEdge == enabledEdges) begin
			item = inFlight.pop_front();
			if (item.valid) begin
				pending--;
				compareField("result.sign", item.value.sign, result.sign);
				compareField("result.exp", item.value.exp, result.exp);
				compareField("result.frac", item.value.frac, result.frac);
			end
		end else if (enabledEdges <= 1) begin
			// The first enabled edge after reset still moves only cleared registers into result
			compareField("result", '0, result);
		end else if (!edgeWasEnabled) begin
			// Stalled pipeline must hold its output
			compareField("result", lastResult, result);
		end
		lastResult = result;
	end

endmodule

`default_nettype wire

//--- bench/recipEstimateTb.sv
// ==========================================================
// Reciprocal estimator testbench
// Drives vectors from the stimulus file, flushes the
// pipeline and prints the closing summary
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module recipEstimateTb;

	import fpFormatPkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 5;
	localparam int DRIVE_DELAY = 1;
	localparam int FLUSH_CYCLES = 3;
	localparam int TIMEOUT_SLACK = 20;
	localparam int MAX_VECTORS = 64;
	// Each vector is ce, operand and expected result
	localparam int WORDS = 3;

	logic clk;
	logic reset;
	logic ce;
	float32T a;
	float32T result;
	float32T expected;
	logic expValid;
	logic loaded = 1'b0;
	int vectorCount;
	int otherErrors;
	logic [31:0] vecMem [0:MAX_VECTORS*WORDS-1];

	recipEstimate dut_i (
		.clk(clk),
		.reset(reset),
		.ce(ce),
		.a(a),
		.result(result)
	);

	recipEstimateMonitor monitor_i (
		.clk(clk),
		.reset(reset),
		.ce(ce),
		.expected(expected),
		.expValid(expValid),
		.result(result)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	// Vectors end at the first word left unloaded
	function automatic int countVectors();
		int count;
		count = 0;
		while (count < MAX_VECTORS && !$isunknown(vecMem[count*WORDS])) begin
			count++;
		end
		return count;
	endfunction

	task automatic applyVector(input logic ceIn, input float32T operand,
			input float32T expectedIn, input logic checkIn);
		ce = ceIn;
		a = operand;
		expected = expectedIn;
		expValid = checkIn;
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	initial begin
		wait (loaded);
		#((vectorCount + TIMEOUT_SLACK) * CLK_PERIOD);
		$display("Timeout: run did not finish within %0d clock cycles",
			vectorCount + TIMEOUT_SLACK);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		int totalErrors;
		clk = 1'b0;
		reset = 1'b1;
		ce = 1'b0;
		a = '0;
		expected = '0;
		expValid = 1'b0;
		otherErrors = 0;
		$readmemh("bench/recipEstimate_stim.txt", vecMem);
		vectorCount = countVectors();
		loaded = 1'b1;
		if (vectorCount == 0) begin
			$display("No vectors were read from the stimulus file");
			otherErrors++;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		for (int i = 0; i < vectorCount; i++) begin
			applyVector(vecMem[i*WORDS][0], vecMem[i*WORDS+1], vecMem[i*WORDS+2], 1'b1);
		end
		// Push the last operands out with ce high
		for (int i = 0; i < FLUSH_CYCLES; i++) begin
			applyVector(1'b1, '0, '0, 1'b0);
		end
		@(negedge clk);
		if (monitor_i.pending != 0) begin
			$display("%0d expected results never appeared on result", monitor_i.pending);
			otherErrors++;
		end
		totalErrors = monitor_i.errorCount + dut_i.checker_i.failCount + otherErrors;
		$display("Closing: %0d errors (%0d compare, %0d assertion, %0d other), %0d checks",
			totalErrors, monitor_i.errorCount, dut_i.checker_i.failCount, otherErrors,
			monitor_i.checkCount);
		if (totalErrors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/recipEstimate_checker.sv
// ==========================================================
// Reciprocal estimator assertions
// Reset clearing, sign and exponent rules three enabled
// edges back, and result holding while ce is low
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module recipEstimateChecker (
	input logic clk,
	input logic reset,
	input logic ce,
	input fpFormatPkg::float32T a,
	input fpFormatPkg::float32T result
);

	import fpFormatPkg::*;

	localparam int LATENCY = 3;
	localparam logic [EXP_WIDTH-1:0] EXP_SUM = 8'd253;

	logic signHist [LATENCY];
	logic [EXP_WIDTH-1:0] expHist [LATENCY];
	int unsigned filled;
	int failCount = 0;

	// Operand history, advancing only on enabled edges
	always_ff @(posedge clk) begin
		if (reset) begin
			filled <= 0;
		end else if (ce) begin
			signHist[0] <= a.sign;
			expHist[0] <= a.exp;
			for (int i = 1; i < LATENCY; i++) begin
				signHist[i] <= signHist[i-1];
				expHist[i] <= expHist[i-1];
			end
			if (filled < LATENCY) begin
				filled <= filled + 1;
			end
		end
	end

	resetClears: assert property (@(posedge clk) reset |=> result == '0)
		else begin
			failCount++;
			$error("result was not cleared by reset");
		end

	signKept: assert property (@(posedge clk) disable iff (reset)
			filled == LATENCY |-> result.sign == signHist[LATENCY-1])
		else begin
			failCount++;
			$error("result sign differs from the operand sign three enabled edges back");
		end

	expNegated: assert property (@(posedge clk) disable iff (reset)
			filled == LATENCY |-> result.exp == EXP_WIDTH'(EXP_SUM - expHist[LATENCY-1]))
		else begin
			failCount++;
			$error("result exponent is not 253 minus the operand exponent");
		end

	stallHolds: assert property (@(posedge clk) disable iff (reset) !ce |=> $stable(result))
		else begin
			failCount++;
			$error("result changed on an edge with ce low");
		end

endmodule

bind recipEstimate recipEstimateChecker checker_i (
	.clk(clk),
	.reset(reset),
	.ce(ce),
	.a(a),
	.result(result)
);

`default_nettype wire

//--- bench/recipEstimate_stim.txt
// Columns: ce, operand a, expected result (all hex)
// Rows with ce low are not accepted and their expected value is ignored
1 3F800000 3F7FFF00
1 BF800000 BF7FFF00
1 3F801000 3F7FE000
1 3F802000 3F7FC000
1 3F803FFF 3F7F8100
1 3FBFE000 3F2AC700
1 3FBFF000 3F2AB900
1 3FBFFFFF 3F2AAB00
1 3FFFE000 3F001000
1 3FFFE001 3F001000
1 3FFFFFFF 3F000000
0 DEADBEEF 00000000
0 12345678 00000000
0 00000000 00000000
1 00800000 7E7FFF00
1 80800000 FE7FFF00
1 7F000000 7FFFFF00
1 FF7FFFFF FF800000
1 40000000 3EFFFF00
0 AAAAAAAA 00000000
1 643FE000 1AAAC700
0 55555555 00000000
0 55555555 00000000
1 9E003FFF E0FF8100
1 00FFE000 7E001000
1 C0BFF000 BE2AB900
1 3F001000 3FFFE000
1 3F7FFFFF 3F800000

//--- files.f
hdl/fpFormatPkg.sv
hdl/recipTablePkg.sv
hdl/pipeDelay.sv
hdl/recipFrontEnd.sv
hdl/recipSlopeRom.sv
hdl/recipInterp.sv
hdl/recipEstimate.sv
bench/recipEstimateMonitor.sv
bench/recipEstimate_checker.sv
bench/recipEstimateTb.sv

//--- hdl/fpFormatPkg.sv
// ==========================================================
// Single-precision floating-point format
// Field widths, exponent bias and the packed word layouts
// shared by the reciprocal estimator stages
// ==========================================================

`default_nettype none

package fpFormatPkg;

	localparam int EXP_WIDTH = 8;
	localparam int FRAC_WIDTH = 23;
	localparam int EXP_BIAS = 127;

	// Reciprocal exponent is this base minus the input exponent
	localparam logic [EXP_WIDTH-1:0] RECIP_EXP_BASE = EXP_WIDTH'(2 * EXP_BIAS - 1);

	// ==========================================================
	// Word layouts
	// ==========================================================

	// IEEE 754 single-precision word, sign in the top bit
	typedef struct packed {
		logic sign;
		logic [EXP_WIDTH-1:0] exp;
		logic [FRAC_WIDTH-1:0] frac;
	} float32T;

	// Sign and reciprocal exponent, carried beside the table read
	typedef struct packed {
		logic sign;
		logic [EXP_WIDTH-1:0] exp;
	} sidebandT;

endpackage

`default_nettype wire

//--- hdl/pipeDelay.sv
// ==========================================================
// Pipeline delay line
// DEPTH registers of any payload type, advancing on ce
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module pipeDelay #(
	parameter int DEPTH = 1,
	parameter type payloadT = logic
) (
	input logic clk,
	input logic reset,
	input logic ce,
	input payloadT din,
	output payloadT dout
);

	payloadT stages [DEPTH];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				stages[i] <= '0;
			end
		end else if (ce) begin
			stages[0] <= din;
			for (int i = 1; i < DEPTH; i++) begin
				stages[i] <= stages[i-1];
			end
		end
	end

	assign dout = stages[DEPTH-1];

endmodule

`default_nettype wire

//--- hdl/recipEstimate.sv
// ==========================================================
// Single-precision reciprocal estimator
// Three-stage pipeline: split, table read, interpolate.
// ce stalls every stage together
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module recipEstimate #(
	parameter int IDX_WIDTH = recipTablePkg::INDEX_WIDTH,
	parameter int OFS_WIDTH = recipTablePkg::EPS_WIDTH,
	parameter int COEF_W = recipTablePkg::COEF_WIDTH,
	parameter int PROD_SHIFT = recipTablePkg::INTERP_SHIFT
) (
	input logic clk,
	input logic reset,
	input logic ce,
	input fpFormatPkg::float32T a,
	output fpFormatPkg::float32T result
);

	import fpFormatPkg::*;
	import recipTablePkg::*;

	// Sign/exponent and offset wait one stage for the table read
	localparam int SIDEBAND_DEPTH = 1;
	localparam int EPS_DEPTH = 1;

	logic [IDX_WIDTH-1:0] index;
	logic [OFS_WIDTH-1:0] eps;
	logic [OFS_WIDTH-1:0] epsAligned;
	sidebandT sideband;
	sidebandT sidebandAligned;
	tableEntryT entry;

	// ==========================================================
	// Stage 1
	// ==========================================================
	recipFrontEnd #(
		.IDX_WIDTH(IDX_WIDTH),
		.OFS_WIDTH(OFS_WIDTH)
	) frontEnd (
		.clk(clk),
		.reset(reset),
		.ce(ce),
		.a(a),
		.index(index),
		.eps(eps),
		.sideband(sideband)
	);

	// ==========================================================
	// Stage 2
	// ==========================================================
	recipSlopeRom #(
		.IDX_WIDTH(IDX_WIDTH)
	) slopeRom (
		.clk(clk),
		.reset(reset),
		.ce(ce),
		.index(index),
		.entry(entry)
	);

	pipeDelay #(
		.DEPTH(SIDEBAND_DEPTH),
		.payloadT(sidebandT)
	) sidebandDelay (
		.clk(clk),
		.reset(reset),
		.ce(ce),
		.din(sideband),
		.dout(sidebandAligned)
	);

	pipeDelay #(
		.DEPTH(EPS_DEPTH),
		.payloadT(logic [OFS_WIDTH-1:0])
	) epsDelay (
		.clk(clk),
		.reset(reset),
		.ce(ce),
		.din(eps),
		.dout(epsAligned)
	);

	// ==========================================================
	// Stage 3
	// ==========================================================
	recipInterp #(
		.OFS_WIDTH(OFS_WIDTH),
		.COEF_W(COEF_W),
		.PROD_SHIFT(PROD_SHIFT)
	) interp (
		.clk(clk),
		.reset(reset),
		.ce(ce),
		.entry(entry),
		.eps(epsAligned),
		.sideband(sidebandAligned),
		.result(result)
	);

endmodule

`default_nettype wire

//--- hdl/recipFrontEnd.sv
// ==========================================================
// Reciprocal front end
// Splits the operand into table index and interpolation
// offset, negates the exponent and registers stage 1
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module recipFrontEnd #(
	parameter int IDX_WIDTH = recipTablePkg::INDEX_WIDTH,
	parameter int OFS_WIDTH = recipTablePkg::EPS_WIDTH
) (
	input logic clk,
	input logic reset,
	input logic ce,
	input fpFormatPkg::float32T a,
	output logic [IDX_WIDTH-1:0] index,
	output logic [OFS_WIDTH-1:0] eps,
	output fpFormatPkg::sidebandT sideband
);

	import fpFormatPkg::*;

	// Fraction bits below the index, and the zeros padding them to the offset width
	localparam int LOW_WIDTH = FRAC_WIDTH - IDX_WIDTH;
	localparam int PAD_WIDTH = OFS_WIDTH - LOW_WIDTH;

	logic [IDX_WIDTH-1:0] indexNext;
	logic [OFS_WIDTH-1:0] epsNext;
	sidebandT sidebandNext;

	assign indexNext = a.frac[FRAC_WIDTH-1 -: IDX_WIDTH];
	assign epsNext = {a.frac[LOW_WIDTH-1:0], {PAD_WIDTH{1'b0}}};

	// 1/2^(e-bias) needs a biased exponent of 2*bias-1-e,
	// since the significand estimate lies in (0.5, 1]
	assign sidebandNext.sign = a.sign;
	assign sidebandNext.exp = RECIP_EXP_BASE - a.exp;

	always_ff @(posedge clk) begin
		if (reset) begin
			index <= '0;
			eps <= '0;
			sideband <= '0;
		end else if (ce) begin
			index <= indexNext;
			eps <= epsNext;
			sideband <= sidebandNext;
		end
	end

endmodule

`default_nettype wire

//--- hdl/recipInterp.sv
// ==========================================================
// Reciprocal interpolation stage
// r = k0 - (k1 * eps >> 26), then assembles and registers
// the output word
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module recipInterp #(
	parameter int OFS_WIDTH = recipTablePkg::EPS_WIDTH,
	parameter int COEF_W = recipTablePkg::COEF_WIDTH,
	parameter int PROD_SHIFT = recipTablePkg::INTERP_SHIFT
) (
	input logic clk,
	input logic reset,
	input logic ce,
	input recipTablePkg::tableEntryT entry,
	input logic [OFS_WIDTH-1:0] eps,
	input fpFormatPkg::sidebandT sideband,
	output fpFormatPkg::float32T result
);

	import fpFormatPkg::*;

	// r's top bit is the implied one and is dropped from the fraction
	localparam int SIG_WIDTH = COEF_W - 1;
	localparam int PAD_WIDTH = FRAC_WIDTH - SIG_WIDTH;

	logic [COEF_W+OFS_WIDTH-1:0] product;
	logic [COEF_W-1:0] correction;
	logic [COEF_W-1:0] diff;

	assign product = entry.k1 * eps;
	assign correction = COEF_W'(product >> PROD_SHIFT);
	assign diff = entry.k0 - correction;

	always_ff @(posedge clk) begin
		if (reset) begin
			result <= '0;
		end else if (ce) begin
			result.sign <= sideband.sign;
			result.exp <= sideband.exp;
			result.frac <= {diff[SIG_WIDTH-1:0], {PAD_WIDTH{1'b0}}};
		end
	end

endmodule

`default_nettype wire

//--- hdl/recipSlopeRom.sv
// ==========================================================
// Reciprocal slope table
// 1024 k0/k1 pairs computed at elaboration, one registered
// read per enabled edge
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module recipSlopeRom #(
	parameter int IDX_WIDTH = recipTablePkg::INDEX_WIDTH
) (
	input logic clk,
	input logic reset,
	input logic ce,
	input logic [IDX_WIDTH-1:0] index,
	output recipTablePkg::tableEntryT entry
);

	import recipTablePkg::*;

	localparam int ENTRIES = 1 << IDX_WIDTH;

	tableEntryT romData [0:ENTRIES-1];

	initial begin
		for (int i = 0; i < ENTRIES; i++) begin
			romData[i] = recipEntry(i);
		end
	end

	// Output register only; the array itself is constant
	always_ff @(posedge clk) begin
		if (reset) begin
			entry <= '0;
		end else if (ce) begin
			entry <= romData[index];
		end
	end

endmodule

`default_nettype wire

//--- hdl/recipTablePkg.sv
// ==========================================================
// Reciprocal segment table
// Table geometry, entry layout and the function that computes
// each k0/k1 pair for the piecewise-linear 1/m estimate
// ==========================================================

`default_nettype none

package recipTablePkg;

	localparam int INDEX_WIDTH = 10;
	localparam int EPS_WIDTH = 16;
	localparam int COEF_WIDTH = 16;
	localparam int INTERP_SHIFT = 26;

	localparam int SEGMENTS = 1 << INDEX_WIDTH;

	// k0 is scaled by 2^26, k1 by 2^36
	localparam int K0_SCALE_LOG2 = 26;
	localparam int K1_SCALE_LOG2 = 36;
	localparam longint unsigned COEF_MAX = (64'd1 << COEF_WIDTH) - 1;

	typedef struct packed {
		logic [COEF_WIDTH-1:0] k0;
		logic [COEF_WIDTH-1:0] k1;
	} tableEntryT;

	// ==========================================================
	// Entry for segment idx, covering m in
	// [(1024+idx)/1024, (1025+idx)/1024)
	// ==========================================================
	function automatic tableEntryT recipEntry(input int unsigned idx);
		longint unsigned seg;
		longint unsigned k0Full;
		longint unsigned k1Full;
		tableEntryT entry;
		seg = longint'(SEGMENTS) + longint'(idx);
		k0Full = (64'd1 << K0_SCALE_LOG2) / seg;
		// Segment 0 would give exactly 2^16
		if (k0Full > COEF_MAX) begin
			k0Full = COEF_MAX;
		end
		k1Full = (64'd1 << K1_SCALE_LOG2) / (seg * (seg + 1));
		entry.k0 = k0Full[COEF_WIDTH-1:0];
		entry.k1 = k1Full[COEF_WIDTH-1:0];
		return entry;
	endfunction

endpackage

`default_nettype wire
